// File: include/dbg_bridge_config.svh
// shared widths and register offsets; offsets are byte addresses and must stay word aligned
`ifndef DBG_BRIDGE_CONFIG_SVH
`define DBG_BRIDGE_CONFIG_SVH

// APB address and data widths, used on both sides of the crossing
`define DBG_ADDR_W 8
`define DBG_DATA_W 32

// flop stages in each req/ack synchroniser
`define DBG_SYNC_STAGES 3

// ---------------------------------------------------------------------------
// register map
// ---------------------------------------------------------------------------
// data bank words sit at base + 0x0, 0x4, 0x8 and 0xc
`define DBG_DATA_BASE 8'h00
`define DBG_DMCONTROL 8'h40
`define DBG_DMSTATUS  8'h44

`endif

// File: logic/dbg_pkg.sv
// APB and debug register types; control and status words are fixed at 32 bits
`default_nettype none

`include "dbg_bridge_config.svh"

package dbg_pkg;

    // -----------------------------------------------------------------------
    // APB request and response
    // -----------------------------------------------------------------------
    // master-driven half of an APB port, 43 bits
    typedef struct packed {
        logic                   psel;
        logic                   penable;
        logic                   pwrite;
        logic [`DBG_ADDR_W-1:0] paddr;
        logic [`DBG_DATA_W-1:0] pwdata;
    } apb_req_t;

    // slave-driven half, 34 bits
    typedef struct packed {
        logic [`DBG_DATA_W-1:0] prdata;
        logic                   pready;
        logic                   pslverr;
    } apb_rsp_t;

    // -----------------------------------------------------------------------
    // debug module register words
    // -----------------------------------------------------------------------
    // control word, bits 29:1 read as zero
    typedef struct packed {
        logic        haltreq;
        logic        resumereq;
        logic [28:0] rsvd_29_1;
        logic        dmactive;
    } dmcontrol_t;

    // status word for a single hart, reserved fields read as zero
    typedef struct packed {
        logic [13:0] rsvd_31_18;
        logic        allresumeack;
        logic [4:0]  rsvd_16_12;
        logic        allrunning;
        logic        rsvd_10;
        logic        allhalted;
        logic [8:0]  rsvd_8_0;
    } dmstatus_t;

endpackage

`default_nettype wire

// File: logic/sync_flops.sv
// single-bit flop-chain synchroniser, stages must be 2 or more; retarget per process if needed
`default_nettype none

module sync_flops #(
    parameter int stages = 3
) (
    // receiving domain clock and its already synchronised reset
    input  wire logic clk_dst,
    input  wire logic rst_n_dst,
    // level from the other domain
    input  wire logic d,
    output logic      q
);

    // shift chain, index 0 is the metastable capture flop
    (* keep = 1'b1 *) logic [stages-1:0] sync_q;

    always_ff @(posedge clk_dst or negedge rst_n_dst) begin
        if (!rst_n_dst) begin
            sync_q <= '0;
        end else begin
            sync_q <= {sync_q[stages-2:0], d};
        end
    end

    // last stage is safe to use in the receiving domain
    assign q = sync_q[stages-1];

endmodule

`default_nettype wire

// File: logic/apb_async_bridge.sv
// APB crossing from clk_src to clk_dst; one transfer at a time, resets synchronised externally
`default_nettype none

`include "dbg_bridge_config.svh"

module apb_async_bridge (
    input  wire logic              clk_src,
    input  wire logic              rst_n_src,
    input  wire logic              clk_dst,
    input  wire logic              rst_n_dst,
    // transport side, clk_src
    input  wire dbg_pkg::apb_req_t src_req,
    output dbg_pkg::apb_rsp_t      src_rsp,
    // debug module side, clk_dst
    output dbg_pkg::apb_req_t      dst_req,
    input  wire dbg_pkg::apb_rsp_t dst_rsp
);

    // captured command is {pwrite, paddr, pwdata}, response is {prdata, pslverr}
    localparam int cmd_w = `DBG_ADDR_W + `DBG_DATA_W + 1;
    localparam int rsp_w = `DBG_DATA_W + 1;

    // -----------------------------------------------------------------------
    // crossing registers
    // -----------------------------------------------------------------------
    // four-phase handshake
    //   src raises req with the command held stable
    //   dst raises ack and runs its own APB transfer
    //   src drops req once ack is seen
    //   dst drops ack when its transfer is over and req is low
    //   src sees ack low, takes the response and completes
    (* keep = 1'b1 *) logic             req_src_q;
    (* keep = 1'b1 *) logic             ack_dst_q;
    (* keep = 1'b1 *) logic [cmd_w-1:0] src_cmd_q;
    (* keep = 1'b1 *) logic [cmd_w-1:0] dst_cmd_q;
    (* keep = 1'b1 *) logic [rsp_w-1:0] dst_resp_q;
    (* keep = 1'b1 *) logic [rsp_w-1:0] src_resp_q;

    // synchronised copies, each in its receiving domain
    logic req_dst;
    logic ack_src;

    sync_flops #(
        .stages (`DBG_SYNC_STAGES)
    ) u_sync_req (
        .clk_dst   (clk_dst),
        .rst_n_dst (rst_n_dst),
        .d         (req_src_q),
        .q         (req_dst)
    );

    // ack goes back, so this copy runs on the source clock
    sync_flops #(
        .stages (`DBG_SYNC_STAGES)
    ) u_sync_ack (
        .clk_dst   (clk_src),
        .rst_n_dst (rst_n_src),
        .d         (ack_dst_q),
        .q         (ack_src)
    );

    // -----------------------------------------------------------------------
    // source side FSM
    // -----------------------------------------------------------------------
    logic src_busy_q;
    logic src_start;
    logic src_done;

    // setup phase only, an access cycle never starts a new transfer
    assign src_start = !src_busy_q && src_req.psel && !src_req.penable;
    // req already dropped and ack seen low again
    assign src_done  = src_busy_q && !req_src_q && !ack_src;

    always_ff @(posedge clk_src or negedge rst_n_src) begin
        if (!rst_n_src) begin
            req_src_q  <= 1'b0;
            src_busy_q <= 1'b0;
        end else if (src_start) begin
            req_src_q  <= 1'b1;
            src_busy_q <= 1'b1;
        end else if (src_busy_q && req_src_q && ack_src) begin
            req_src_q  <= 1'b0;
        end else if (src_done) begin
            src_busy_q <= 1'b0;
        end
    end

    // payload paths
    always_ff @(posedge clk_src) begin
        if (src_start) begin
            src_cmd_q <= {src_req.pwrite, src_req.paddr, src_req.pwdata};
        end
        // dst_resp_q has been still for the whole ack synchroniser delay
        if (src_done) begin
            src_resp_q <= dst_resp_q;
        end
    end

    // pready low for as long as the handshake is in progress
    always_comb begin
        src_rsp.prdata  = src_resp_q[rsp_w-1:1];
        src_rsp.pslverr = src_resp_q[0];
        src_rsp.pready  = !src_busy_q;
    end

    // -----------------------------------------------------------------------
    // destination side
    // -----------------------------------------------------------------------
    logic dst_psel_q;
    logic dst_penable_q;
    logic dst_start;
    logic dst_finish;

    assign dst_start  = req_dst && !ack_dst_q;
    assign dst_finish = dst_psel_q && dst_penable_q && dst_rsp.pready;

    // ack falls only when the local transfer has ended and req is gone
    always_ff @(posedge clk_dst or negedge rst_n_dst) begin
        if (!rst_n_dst) begin
            ack_dst_q <= 1'b0;
        end else if (dst_start) begin
            ack_dst_q <= 1'b1;
        end else if (ack_dst_q && !req_dst && !dst_psel_q) begin
            ack_dst_q <= 1'b0;
        end
    end

    // setup, then access until the slave gives pready
    always_ff @(posedge clk_dst or negedge rst_n_dst) begin
        if (!rst_n_dst) begin
            dst_psel_q    <= 1'b0;
            dst_penable_q <= 1'b0;
        end else if (dst_start) begin
            dst_psel_q    <= 1'b1;
        end else if (dst_psel_q && !dst_penable_q) begin
            dst_penable_q <= 1'b1;
        end else if (dst_finish) begin
            dst_psel_q    <= 1'b0;
            dst_penable_q <= 1'b0;
        end
    end

    // src_cmd_q has been still for the whole req synchroniser delay
    always_ff @(posedge clk_dst) begin
        if (dst_start) begin
            dst_cmd_q <= src_cmd_q;
        end
        if (dst_finish) begin
            dst_resp_q <= {dst_rsp.prdata, dst_rsp.pslverr};
        end
    end

    always_comb begin
        dst_req.psel    = dst_psel_q;
        dst_req.penable = dst_penable_q;
        dst_req.pwrite  = dst_cmd_q[cmd_w-1];
        dst_req.paddr   = dst_cmd_q[cmd_w-2:`DBG_DATA_W];
        dst_req.pwdata  = dst_cmd_q[`DBG_DATA_W-1:0];
    end

endmodule

`default_nettype wire

// File: logic/dm_data_bank.sv
// four scratch data words at zero wait states; only paddr bits 3:2 are decoded here
`default_nettype none

`include "dbg_bridge_config.svh"

module dm_data_bank (
    input  wire logic              clk_dst,
    input  wire logic              rst_n_dst,
    // psel already qualified by the fabric decode
    input  wire dbg_pkg::apb_req_t req,
    output dbg_pkg::apb_rsp_t      rsp
);

    // ---------------------------------------------------------------------------
    // register storage
    // ---------------------------------------------------------------------------
    logic [`DBG_DATA_W-1:0] words_q [4];
    logic [1:0]             word_idx;
    logic                   wr_en;

    // word select from the byte address
    assign word_idx = req.paddr[3:2];

    // the first access cycle is also the last, so the write lands there
    assign wr_en = req.psel && req.penable && req.pwrite;

    always_ff @(posedge clk_dst or negedge rst_n_dst) begin
        if (!rst_n_dst) begin
            for (int i = 0; i < 4; i++) begin
                words_q[i] <= '0;
            end
        end else if (wr_en) begin
            words_q[word_idx] <= req.pwdata;
        end
    end

    // ---------------------------------------------------------------------------
    // response
    // ---------------------------------------------------------------------------
    // read data straight from the selected word
    // never stalls and never errors
    always_comb begin
        rsp.prdata  = words_q[word_idx];
        rsp.pready  = 1'b1;
        rsp.pslverr = 1'b0;
    end

endmodule

`default_nettype wire

// File: logic/dm_halt_ctrl.sv
// halt/resume control for a single hart; one wait state per access, status is read-only
`default_nettype none

`include "dbg_bridge_config.svh"

module dm_halt_ctrl (
    input  wire logic              clk_dst,
    input  wire logic              rst_n_dst,
    // psel already qualified, paddr is one of the two halt registers
    input  wire dbg_pkg::apb_req_t req,
    output dbg_pkg::apb_rsp_t      rsp,
    // hart side levels
    input  wire logic              hart_halted,
    output logic                   halt_req,
    output logic                   resume_req
);

    dbg_pkg::dmcontrol_t ctrl_q;
    dbg_pkg::dmcontrol_t wr_ctrl;
    dbg_pkg::dmstatus_t  status;
    logic                wait_q;
    logic                access;
    logic                is_status;
    logic                wr_done;

    // ---------------------------------------------------------------------------
    // access timing
    // ---------------------------------------------------------------------------
    assign access    = req.psel && req.penable;
    assign is_status = req.paddr == `DBG_DMSTATUS;

    // low on the first access cycle, high on the second, back to low after
    always_ff @(posedge clk_dst or negedge rst_n_dst) begin
        if (!rst_n_dst) begin
            wait_q <= 1'b0;
        end else if (access) begin
            wait_q <= !wait_q;
        end else begin
            wait_q <= 1'b0;
        end
    end

    // ---------------------------------------------------------------------------
    // control register
    // ---------------------------------------------------------------------------
    // control writes commit on the completing edge only
    assign wr_done = access && wait_q && req.pwrite && !is_status;
    assign wr_ctrl = dbg_pkg::dmcontrol_t'(req.pwdata);

    // reserved bits stay at their reset zero
    always_ff @(posedge clk_dst or negedge rst_n_dst) begin
        if (!rst_n_dst) begin
            ctrl_q <= '0;
        end else if (wr_done) begin
            ctrl_q.haltreq   <= wr_ctrl.haltreq;
            ctrl_q.resumereq <= wr_ctrl.resumereq;
            ctrl_q.dmactive  <= wr_ctrl.dmactive;
        end else if (ctrl_q.resumereq && !hart_halted) begin
            // hart is running again, so the resume is done
            ctrl_q.resumereq <= 1'b0;
        end
    end

    // requests only reach the hart while the module is active
    assign halt_req   = ctrl_q.haltreq && ctrl_q.dmactive;
    assign resume_req = ctrl_q.resumereq && ctrl_q.dmactive;

    // ---------------------------------------------------------------------------
    // status and response
    // ---------------------------------------------------------------------------
    always_comb begin
        status              = '0;
        status.allhalted    = hart_halted;
        status.allrunning   = !hart_halted;
        // single hart, running counts as resumed
        status.allresumeack = status.allrunning;
    end

    always_comb begin
        rsp.prdata  = is_status ? status : ctrl_q;
        rsp.pready  = wait_q;
        // status is read-only
        rsp.pslverr = is_status && req.pwrite;
    end

endmodule

`default_nettype wire

// File: logic/dm_apb_fabric.sv
// combinational decode and response merge; data words must be word aligned or they go unmapped
`default_nettype none

`include "dbg_bridge_config.svh"

module dm_apb_fabric (
    // from the bridge
    input  wire dbg_pkg::apb_req_t req,
    output dbg_pkg::apb_rsp_t      rsp,
    // data bank port
    output dbg_pkg::apb_req_t      data_req,
    input  wire dbg_pkg::apb_rsp_t data_rsp,
    // halt control port
    output dbg_pkg::apb_req_t      ctrl_req,
    input  wire dbg_pkg::apb_rsp_t ctrl_rsp
);

    localparam logic [`DBG_ADDR_W-1:0] data_base = `DBG_DATA_BASE;

    logic sel_data;
    logic sel_ctrl;

    // ---------------------------------------------------------------------------
    // address decode
    // ---------------------------------------------------------------------------
    // data bank takes the four aligned words above its base
    assign sel_data = (req.paddr[`DBG_ADDR_W-1:4] == data_base[`DBG_ADDR_W-1:4])
                   && (req.paddr[1:0] == 2'b00);
    assign sel_ctrl = (req.paddr == `DBG_DMCONTROL) || (req.paddr == `DBG_DMSTATUS);

    // ---------------------------------------------------------------------------
    // request fan-out
    // ---------------------------------------------------------------------------
    // everything passes through, psel only to the decoded part
    always_comb begin
        data_req      = req;
        data_req.psel = req.psel && sel_data;
        ctrl_req      = req;
        ctrl_req.psel = req.psel && sel_ctrl;
    end

    // ---------------------------------------------------------------------------
    // response merge
    // ---------------------------------------------------------------------------
    always_comb begin
        if (sel_data) begin
            rsp = data_rsp;
        end else if (sel_ctrl) begin
            rsp = ctrl_rsp;
        end else begin
            // unmapped, error in the first access cycle with zero data
            rsp.prdata  = '0;
            rsp.pready  = 1'b1;
            rsp.pslverr = 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: logic/dbg_bridge_top.sv
// debug access path top level; clk_src and clk_dst resets must be synchronised outside
`default_nettype none

module dbg_bridge_top (
    // transport domain
    input  wire logic              clk_src,
    input  wire logic              rst_n_src,
    // debug module domain
    input  wire logic              clk_dst,
    input  wire logic              rst_n_dst,
    // transport APB port, clk_src
    input  wire dbg_pkg::apb_req_t src_req,
    output dbg_pkg::apb_rsp_t      src_rsp,
    // hart levels, clk_dst
    input  wire logic              hart_halted,
    output logic                   halt_req,
    output logic                   resume_req
);

    // clk_dst side APB nets
    dbg_pkg::apb_req_t dst_req;
    dbg_pkg::apb_rsp_t dst_rsp;
    dbg_pkg::apb_req_t data_req;
    dbg_pkg::apb_rsp_t data_rsp;
    dbg_pkg::apb_req_t ctrl_req;
    dbg_pkg::apb_rsp_t ctrl_rsp;

    apb_async_bridge u_apb_async_bridge (
        .clk_src   (clk_src),
        .rst_n_src (rst_n_src),
        .clk_dst   (clk_dst),
        .rst_n_dst (rst_n_dst),
        .src_req   (src_req),
        .src_rsp   (src_rsp),
        .dst_req   (dst_req),
        .dst_rsp   (dst_rsp)
    );

    dm_apb_fabric u_dm_apb_fabric (
        .req      (dst_req),
        .rsp      (dst_rsp),
        .data_req (data_req),
        .data_rsp (data_rsp),
        .ctrl_req (ctrl_req),
        .ctrl_rsp (ctrl_rsp)
    );

    dm_data_bank u_dm_data_bank (
        .clk_dst   (clk_dst),
        .rst_n_dst (rst_n_dst),
        .req       (data_req),
        .rsp       (data_rsp)
    );

    dm_halt_ctrl u_dm_halt_ctrl (
        .clk_dst     (clk_dst),
        .rst_n_dst   (rst_n_dst),
        .req         (ctrl_req),
        .rsp         (ctrl_rsp),
        .hart_halted (hart_halted),
        .halt_req    (halt_req),
        .resume_req  (resume_req)
    );

endmodule

`default_nettype wire

// File: testbench/dbg_bridge_sva.sv
// bridge handshake and APB checks; bound to apb_async_bridge, needs both resets released
`default_nettype none

module dbg_bridge_sva (
    input wire logic              clk_src,
    input wire logic              rst_n_src,
    input wire logic              clk_dst,
    input wire logic              rst_n_dst,
    input wire dbg_pkg::apb_rsp_t src_rsp,
    input wire dbg_pkg::apb_req_t dst_req,
    input wire dbg_pkg::apb_rsp_t dst_rsp,
    input wire logic              req_src_q,
    input wire logic              ack_src
);

    // raised by any failing assertion, watched from the testbench
    logic assert_failed = 1'b0;

    // ------------------------------------------------------------------------
    // source side handshake
    // ------------------------------------------------------------------------
    // request is held until the synchronised ack comes back
    a_req_held : assert property (@(posedge clk_src) disable iff (!rst_n_src)
        req_src_q && !ack_src |=> req_src_q)
        else begin assert_failed = 1'b1; $error("req dropped before ack"); end

    // no completion until req is gone and ack has come back low
    a_pready_low : assert property (@(posedge clk_src) disable iff (!rst_n_src)
        req_src_q || ack_src |-> !src_rsp.pready)
        else begin assert_failed = 1'b1; $error("src pready high during the handshake"); end

    // ------------------------------------------------------------------------
    // destination APB protocol
    // ------------------------------------------------------------------------
    // setup is always followed by access
    a_setup_access : assert property (@(posedge clk_dst) disable iff (!rst_n_dst)
        dst_req.psel && !dst_req.penable |=> dst_req.psel && dst_req.penable)
        else begin assert_failed = 1'b1; $error("setup not followed by access"); end

    // psel held until the slave is ready
    a_psel_held : assert property (@(posedge clk_dst) disable iff (!rst_n_dst)
        dst_req.psel && !(dst_req.penable && dst_rsp.pready) |=> dst_req.psel)
        else begin assert_failed = 1'b1; $error("dst psel dropped before pready"); end

    // command fields frozen through access
    a_cmd_stable : assert property (@(posedge clk_dst) disable iff (!rst_n_dst)
        dst_req.psel && dst_req.penable
        |-> $stable({dst_req.pwrite, dst_req.paddr, dst_req.pwdata}))
        else begin assert_failed = 1'b1; $error("dst command changed in access"); end

endmodule

bind apb_async_bridge dbg_bridge_sva u_bridge_sva (
    .clk_src   (clk_src),
    .rst_n_src (rst_n_src),
    .clk_dst   (clk_dst),
    .rst_n_dst (rst_n_dst),
    .src_rsp   (src_rsp),
    .dst_req   (dst_req),
    .dst_rsp   (dst_rsp),
    .req_src_q (req_src_q),
    .ack_src   (ack_src)
);

`default_nettype wire

// File: testbench/dbg_bridge_tb.sv
// testbench for the debug access path; single source master, one transfer in flight, fixed seed
`default_nettype none

`include "dbg_bridge_config.svh"

module dbg_bridge_tb;

    // one source transfer as seen just before its completing edge
    typedef struct {
        string                  name;
        logic                   pwrite;
        logic [`DBG_ADDR_W-1:0] paddr;
        logic [`DBG_DATA_W-1:0] pwdata;
        logic                   halted;
        dbg_pkg::apb_rsp_t      rsp;
        dbg_pkg::dmcontrol_t    levels;
        // destination completions counted so far
        int                     dst_seen;
    } xfer_t;

    localparam int src_period = 7;
    localparam int n_random   = 300;
    // directed transfers stay well under 32
    localparam int n_xfers    = n_random + 32;

    logic              clk_src;
    logic              clk_dst;
    logic              rst_n_src;
    logic              rst_n_dst;
    dbg_pkg::apb_req_t src_req;
    dbg_pkg::apb_rsp_t src_rsp;
    logic              hart_halted;
    logic              halt_req;
    logic              resume_req;

    xfer_t done_q[$];
    int    issued_count = 0;
    int    checked_count = 0;
    int    dst_count = 0;

    // register model state
    logic [`DBG_DATA_W-1:0] model_words [4] = '{default: '0};
    logic                   model_halt = 1'b0;
    logic                   model_resume = 1'b0;
    logic                   model_active = 1'b0;

    dbg_bridge_top u_dbg_bridge_top (
        .clk_src     (clk_src),
        .rst_n_src   (rst_n_src),
        .clk_dst     (clk_dst),
        .rst_n_dst   (rst_n_dst),
        .src_req     (src_req),
        .src_rsp     (src_rsp),
        .hart_halted (hart_halted),
        .halt_req    (halt_req),
        .resume_req  (resume_req)
    );

    // ------------------------------------------------------------------------
    // clocks, watchdog, assertion monitor
    // ------------------------------------------------------------------------
    initial begin
        clk_dst = 1'b0;
        forever #2 clk_dst = ~clk_dst;
    end

    // 7 unit period, uneven halves
    initial begin
        clk_src = 1'b0;
        forever begin
            #3 clk_src = 1'b1;
            #4 clk_src = 1'b0;
        end
    end

    initial begin
        #(n_xfers * 200 * src_period);
        $display("timeout: the run did not finish within %0d time units",
                 n_xfers * 200 * src_period);
        end_with_failure();
    end

    initial begin
        wait (u_dbg_bridge_top.u_apb_async_bridge.u_bridge_sva.assert_failed === 1'b1);
        $display("a bridge protocol assertion failed");
        end_with_failure();
    end

    task automatic end_with_failure();
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    // ------------------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------------------
    // resumereq self clears while the hart runs; gives the hart side levels
    function automatic dbg_pkg::dmcontrol_t model_levels(input logic halted);
        dbg_pkg::dmcontrol_t lv;
        if (!halted) begin
            model_resume = 1'b0;
        end
        lv           = '0;
        lv.haltreq   = model_halt && model_active;
        lv.resumereq = model_resume && model_active;
        return lv;
    endfunction

    function automatic dbg_pkg::apb_rsp_t model_access(input logic pwrite,
            input logic [`DBG_ADDR_W-1:0] paddr, input logic [`DBG_DATA_W-1:0] pwdata,
            input logic halted);
        dbg_pkg::apb_rsp_t      r;
        logic [`DBG_DATA_W-1:0] st;
        r = '{prdata: '0, pready: 1'b1, pslverr: 1'b0};
        if (!halted) begin
            model_resume = 1'b0;
        end
        // aligned data words, bits 3:2 pick the word
        if ((paddr & 8'hf3) == `DBG_DATA_BASE) begin
            if (pwrite) begin
                model_words[paddr[3:2]] = pwdata;
            end else begin
                r.prdata = model_words[paddr[3:2]];
            end
        end else if (paddr == `DBG_DMCONTROL) begin
            if (pwrite) begin
                model_halt   = pwdata[31];
                model_resume = pwdata[30];
                model_active = pwdata[0];
            end else begin
                r.prdata = {model_halt, model_resume, 29'd0, model_active};
            end
        end else if (paddr == `DBG_DMSTATUS) begin
            // allhalted 9, allrunning 11, allresumeack 17
            st     = '0;
            st[9]  = halted;
            st[11] = !halted;
            st[17] = !halted;
            r.prdata  = pwrite ? '0 : st;
            r.pslverr = pwrite;
        end else begin
            r.pslverr = 1'b1;
        end
        return r;
    endfunction

    // ------------------------------------------------------------------------
    // compare tasks and process
    // ------------------------------------------------------------------------
    // prdata only means something on reads
    task automatic check_rsp(input string name, input dbg_pkg::apb_rsp_t exp,
            input dbg_pkg::apb_rsp_t act, input logic cmp_data);
        if (act.pslverr !== exp.pslverr || (cmp_data && act.prdata !== exp.prdata)) begin
            $display("Fail %s expected prdata=%h pslverr=%b actual prdata=%h pslverr=%b",
                     name, exp.prdata, exp.pslverr, act.prdata, act.pslverr);
            end_with_failure();
        end
    endtask

    task automatic check_levels(input string name, input dbg_pkg::dmcontrol_t exp,
            input dbg_pkg::dmcontrol_t act);
        if (act !== exp) begin
            $display("Fail %s expected levels %h actual levels %h", name, exp, act);
            end_with_failure();
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("Fail %s expected dst transfers %0d actual dst transfers %0d",
                     name, exp, act);
            end_with_failure();
        end
    endtask

    // destination completions, one per source transfer when none is lost or repeated
    always @(posedge clk_dst) begin
        if (u_dbg_bridge_top.dst_req.psel && u_dbg_bridge_top.dst_req.penable
                && u_dbg_bridge_top.dst_rsp.pready) begin
            dst_count++;
        end
    end

    initial begin
        xfer_t             x;
        dbg_pkg::apb_rsp_t exp;
        forever begin
            wait (done_q.size() != 0);
            x   = done_q.pop_front();
            exp = model_access(x.pwrite, x.paddr, x.pwdata, x.halted);
            check_rsp(x.name, exp, x.rsp, !x.pwrite);
            check_levels(x.name, model_levels(x.halted), x.levels);
            check_count(x.name, checked_count + 1, x.dst_seen);
            checked_count++;
        end
    end

    // ------------------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------------------
    // source master, setup then access until pready
    task automatic apb_xfer(input string name, input logic wr,
            input logic [`DBG_ADDR_W-1:0] addr, input logic [`DBG_DATA_W-1:0] data);
        xfer_t x;
        @(negedge clk_src);
        src_req = '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: data};
        @(negedge clk_src);
        src_req.penable = 1'b1;
        // pready only moves on clk_src rising edges
        while (src_rsp.pready !== 1'b1) begin
            @(negedge clk_src);
        end
        x.name             = name;
        x.pwrite           = wr;
        x.paddr            = addr;
        x.pwdata           = data;
        x.halted           = hart_halted;
        x.rsp              = src_rsp;
        x.levels           = '0;
        x.levels.haltreq   = halt_req;
        x.levels.resumereq = resume_req;
        x.dst_seen         = dst_count;
        @(posedge clk_src);
        @(negedge clk_src);
        src_req.psel    = 1'b0;
        src_req.penable = 1'b0;
        issued_count++;
        done_q.push_back(x);
    endtask

    task automatic set_halted(input logic v);
        @(negedge clk_dst);
        hart_halted = v;
    endtask

    initial begin
        dbg_pkg::dmcontrol_t    lv_act;
        int                     sel;
        logic [`DBG_ADDR_W-1:0] addr;
        void'($urandom(32'h4844));
        src_req     = '0;
        hart_halted = 1'b0;
        rst_n_src   = 1'b0;
        rst_n_dst   = 1'b0;
        repeat (16) @(posedge clk_dst);
        @(negedge clk_dst);
        rst_n_dst = 1'b1;
        rst_n_src = 1'b1;
        @(negedge clk_src);
        if (src_rsp.pready !== 1'b1) begin
            $display("src pready is not high after reset");
            end_with_failure();
        end

        // data words
        for (int i = 0; i < 4; i++) begin
            apb_xfer($sformatf("data_wr_%0d", i), 1'b1, `DBG_DATA_BASE + 4 * i,
                     32'hdead_0000 + 32'h0101_0101 * i);
        end
        for (int i = 0; i < 4; i++) begin
            apb_xfer($sformatf("data_rd_%0d", i), 1'b0, `DBG_DATA_BASE + 4 * i, '0);
        end

        // halt request with and without dmactive
        apb_xfer("halt_inactive", 1'b1, `DBG_DMCONTROL, 32'h8000_0000);
        apb_xfer("halt_inactive_rd", 1'b0, `DBG_DMCONTROL, '0);
        apb_xfer("halt_active", 1'b1, `DBG_DMCONTROL, 32'h8000_0001);
        apb_xfer("halt_active_rd", 1'b0, `DBG_DMCONTROL, '0);

        // status follows the hart
        set_halted(1'b1);
        apb_xfer("status_halted", 1'b0, `DBG_DMSTATUS, '0);
        set_halted(1'b0);
        apb_xfer("status_running", 1'b0, `DBG_DMSTATUS, '0);

        // resume request clears once the hart runs
        set_halted(1'b1);
        apb_xfer("resume_set", 1'b1, `DBG_DMCONTROL, 32'h4000_0001);
        set_halted(1'b0);
        repeat (4) @(negedge clk_dst);
        wait (checked_count == issued_count);
        lv_act           = '0;
        lv_act.haltreq   = halt_req;
        lv_act.resumereq = resume_req;
        check_levels("resume_clear", model_levels(hart_halted), lv_act);
        apb_xfer("resume_rd", 1'b0, `DBG_DMCONTROL, '0);

        // error responses
        apb_xfer("unmapped_rd", 1'b0, 8'h20, '0);
        apb_xfer("unmapped_wr", 1'b1, 8'h20, 32'h1234_5678);
        apb_xfer("unmapped_rd_hi", 1'b0, 8'h48, '0);
        apb_xfer("misaligned_rd", 1'b0, 8'h01, '0);
        apb_xfer("status_wr", 1'b1, `DBG_DMSTATUS, 32'hffff_ffff);

        // random mix, mapped registers weighted up
        for (int i = 0; i < n_random; i++) begin
            if ($urandom % 16 == 0) begin
                set_halted($urandom % 2);
            end
            sel = $urandom % 8;
            case (sel)
                0, 1, 2, 3: addr = `DBG_DATA_BASE + 4 * sel;
                4:          addr = `DBG_DMCONTROL;
                5:          addr = `DBG_DMSTATUS;
                default:    addr = $urandom;
            endcase
            apb_xfer($sformatf("random_%0d", i), $urandom % 2, addr, $urandom);
        end

        @(negedge clk_src);
        if (checked_count != issued_count || dst_count != issued_count) begin
            $display("%0d transfers issued, %0d reached the destination, %0d compared",
                     issued_count, dst_count, checked_count);
            end_with_failure();
        end else begin
            $display("TEST RESULT: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: list.f
+incdir+include
logic/dbg_pkg.sv
logic/sync_flops.sv
logic/apb_async_bridge.sv
logic/dm_data_bank.sv
logic/dm_halt_ctrl.sv
logic/dm_apb_fabric.sv
logic/dbg_bridge_top.sv
testbench/dbg_bridge_sva.sv
testbench/dbg_bridge_tb.sv
